// File: include/io_settings.svh
// Build-time settings for the memory-mapped I/O block.
// Included by the RTL that needs the I/O window, the UART bit period
// or the line engine flow-control sizes.

`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// Start of the 256-byte I/O window
`define IO_BASE_ADDR 32'h8000_0000

// UART bit period in clocks, no runtime baud programming
`define UART_CLKS_PER_BIT 8

// Commands the line engine takes before it returns a credit
`define LE_CREDITS 2

// Entries in the command queue
`define LE_QUEUE_DEPTH 4

`endif

// File: verilog/io_bus_pkg.sv
// Types shared by the CPU side of the I/O block.
// Covers the request bundle, the major opcodes seen on it, and the
// register offsets inside the I/O window.

package io_bus_pkg;

    // RISC-V major opcodes of interest
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b000_0011,
        OP_STORE = 7'b010_0011,
        OP_OTHER = 7'b001_0011
    } cpu_op_e;

    typedef struct packed {
        logic        valid;
        cpu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    // Offsets from the window base
    typedef enum logic [7:0] {
        UART_STATUS = 8'h00,
        UART_RXDATA = 8'h04,
        UART_TXDATA = 8'h08,
        CYCLES      = 8'h10,
        INSTRS      = 8'h14,
        CNT_CLEAR   = 8'h18,
        LE_STATUS   = 8'h24,
        LE_COLOR    = 8'h28,
        X0          = 8'h30,
        Y0          = 8'h34,
        X1          = 8'h38,
        Y1          = 8'h3C,
        X0_GO       = 8'h40,
        Y0_GO       = 8'h44,
        X1_GO       = 8'h48,
        Y1_GO       = 8'h4C
    } io_reg_e;

endpackage

// File: verilog/line_engine_pkg.sv
// Types for the command interface of the external line engine.
// One command word carries a field select, its value and a trigger
// bit that starts drawing once the field is written.

package line_engine_pkg;

    // Which engine register a command writes
    typedef enum logic [2:0] {
        FIELD_COLOR = 3'd0,
        FIELD_X0    = 3'd1,
        FIELD_Y0    = 3'd2,
        FIELD_X1    = 3'd3,
        FIELD_Y1    = 3'd4
    } le_field_e;

    // Points use value[9:0], color uses all 24 bits
    typedef struct packed {
        le_field_e   field;
        logic [23:0] value;
        logic        trigger;
    } le_cmd_t;

endpackage

// File: verilog/uart_tx.sv
// UART transmitter, 8N1, LSB first.
// A byte is taken on tx_valid while tx_ready is high; the line is busy
// for ten bit periods, start bit through stop bit.

`timescale 1ns/1ps

`include "io_settings.svh"

module uart_tx (
    input  logic       Clock,
    input  logic       rst_n,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       tx_ready,
    output logic       serial_out
);

    localparam int CLKS  = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS - 1);

    logic             busy;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    // Frame shifts out of bit 0, idle fill is ones
    logic [9:0]       shift;

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shift   <= '1;
        end else if (!busy) begin
            if (tx_valid) begin
                shift   <= {1'b1, tx_byte, 1'b0};
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            shift   <= {1'b1, shift[9:1]};
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign tx_ready   = !busy;
    assign serial_out = shift[0];

    // Decoder must drop stores that arrive mid-frame
    a_no_send_while_busy : assert property (
        @(posedge Clock) disable iff (!rst_n) tx_valid |-> !busy);

endmodule

// File: verilog/uart_rx.sv
// UART receiver, 8N1, LSB first.
// Samples each bit at its middle and holds the finished byte with
// rx_valid until rx_pop. A new byte replaces an unread one.

`timescale 1ns/1ps

`include "io_settings.svh"

module uart_rx (
    input  logic       Clock,
    input  logic       rst_n,
    input  logic       serial_in,
    output logic       rx_valid,
    output logic [7:0] rx_byte,
    input  logic       rx_pop
);

    localparam int CLKS  = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [1:0]       sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], serial_in};
        end
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_pop) begin
                rx_valid <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch check at the middle of the start bit
                        state   <= sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        shift   <= {sync[1], shift[7:1]};
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == BIT_LAST) begin
                        rx_byte  <= shift;
                        rx_valid <= 1'b1;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: verilog/le_cmd_port.sv
// Command port toward the line engine.
// Queues decoder commands and issues them in order, one per credit.
// The engine returns a credit per accepted command with le_credit.

`timescale 1ns/1ps

`include "io_settings.svh"

module le_cmd_port (
    input  logic                     Clock,
    input  logic                     rst_n,
    input  logic                     enq_valid,
    input  line_engine_pkg::le_cmd_t enq_cmd,
    output logic [2:0]               free_slots,
    output logic                     overflow,
    input  logic                     overflow_clear,
    input  logic                     le_credit,
    output logic                     le_cmd_valid,
    output line_engine_pkg::le_cmd_t le_cmd
);

    localparam int DEPTH   = `LE_QUEUE_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CREDITS = `LE_CREDITS;
    localparam int CRED_W  = $clog2(CREDITS + 1);

    line_engine_pkg::le_cmd_t mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [2:0]        count;
    logic [CRED_W-1:0] credits;
    logic              full;
    logic              do_enq;
    logic              issue;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full       = (count == 3'(DEPTH));
    assign do_enq     = enq_valid && !full;
    assign issue      = (count != '0) && (credits != '0);
    assign free_slots = 3'(DEPTH) - count;

    always_ff @(posedge Clock) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_cmd;
        end
        if (issue) begin
            le_cmd <= mem[rd_ptr];
        end
    end

    // ------------------------------
    // Pointers, credits, status
    // ------------------------------
    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credits      <= CRED_W'(CREDITS);
            overflow     <= 1'b0;
            le_cmd_valid <= 1'b0;
        end else begin
            le_cmd_valid <= issue;
            if (do_enq) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_enq, issue})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
            case ({le_credit, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            // Set wins over a same-cycle clear
            if (enq_valid && full) begin
                overflow <= 1'b1;
            end else if (overflow_clear) begin
                overflow <= 1'b0;
            end
        end
    end

    a_credit_bound : assert property (
        @(posedge Clock) disable iff (!rst_n) credits <= CRED_W'(CREDITS));

endmodule

// File: verilog/io_decoder.sv
// Address decoder and register block for the I/O window.
// Owns the cycle and instruction counters, answers loads one cycle
// after the request and steers stores to the UART and command port.

`timescale 1ns/1ps

`include "io_settings.svh"

module io_decoder (
    input  logic                     Clock,
    input  logic                     rst_n,
    input  io_bus_pkg::cpu_req_t     req,
    input  logic                     stall,
    output logic [31:0]              rdata,
    output logic                     rdata_valid,
    output logic                     tx_valid,
    output logic [7:0]               tx_byte,
    input  logic                     tx_ready,
    input  logic                     rx_valid,
    input  logic [7:0]               rx_byte,
    output logic                     rx_pop,
    output logic                     enq_valid,
    output line_engine_pkg::le_cmd_t enq_cmd,
    input  logic [2:0]               free_slots,
    input  logic                     overflow,
    output logic                     overflow_clear
);

    localparam logic [31:0] BASE = `IO_BASE_ADDR;

    io_bus_pkg::io_reg_e        reg_sel;
    line_engine_pkg::le_field_e fld;
    logic        hit;
    logic        load_hit;
    logic        store_hit;
    logic        le_sel;
    logic        go;
    logic        cnt_clear;
    logic [31:0] rd_word;
    logic [31:0] cycles;
    logic [31:0] instrs;

    // ------------------------------
    // Window and offset decode
    // ------------------------------
    assign hit       = req.valid && (req.addr[31:8] == BASE[31:8]);
    assign load_hit  = hit && (req.op == io_bus_pkg::OP_LOAD);
    assign store_hit = hit && (req.op == io_bus_pkg::OP_STORE);
    assign reg_sel   = io_bus_pkg::io_reg_e'(req.addr[7:0]);

    always_comb begin
        rd_word = '0;
        le_sel  = 1'b0;
        go      = 1'b0;
        fld     = line_engine_pkg::FIELD_COLOR;
        case (reg_sel)
            io_bus_pkg::UART_STATUS: rd_word = {30'b0, rx_valid, tx_ready};
            io_bus_pkg::UART_RXDATA: rd_word = {24'b0, rx_byte};
            io_bus_pkg::CYCLES:      rd_word = cycles;
            io_bus_pkg::INSTRS:      rd_word = instrs;
            io_bus_pkg::LE_STATUS:   rd_word = {23'b0, overflow, 5'b0, free_slots};
            io_bus_pkg::LE_COLOR:    le_sel  = 1'b1;
            io_bus_pkg::X0, io_bus_pkg::Y0, io_bus_pkg::X1, io_bus_pkg::Y1,
            io_bus_pkg::X0_GO, io_bus_pkg::Y0_GO, io_bus_pkg::X1_GO,
            io_bus_pkg::Y1_GO: begin
                le_sel = 1'b1;
                // Point index from addr[3:2]
                // GO block starts at 0x40
                fld    = line_engine_pkg::le_field_e'({1'b0, req.addr[3:2]} + 3'd1);
                go     = req.addr[6];
            end
            default: rd_word = '0;
        endcase
    end

    // Side effects take hold on the edge that ends the request cycle
    assign tx_valid       = store_hit && (reg_sel == io_bus_pkg::UART_TXDATA) && tx_ready;
    assign tx_byte        = req.wdata[7:0];
    assign rx_pop         = load_hit && (reg_sel == io_bus_pkg::UART_RXDATA);
    assign overflow_clear = load_hit && (reg_sel == io_bus_pkg::LE_STATUS);
    assign cnt_clear      = store_hit && (reg_sel == io_bus_pkg::CNT_CLEAR);
    assign enq_valid      = store_hit && le_sel;

    assign enq_cmd = '{
        field:   fld,
        value:   (fld == line_engine_pkg::FIELD_COLOR) ? req.wdata[23:0]
                                                      : {14'b0, req.wdata[9:0]},
        trigger: go
    };

    // ------------------------------
    // Counters and read data
    // ------------------------------
    always_ff @(posedge Clock) begin
        if (!rst_n || cnt_clear) begin
            cycles <= '0;
            instrs <= '0;
        end else begin
            cycles <= cycles + 32'd1;
            if (!stall) begin
                instrs <= instrs + 32'd1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= load_hit;
        end
        rdata <= load_hit ? rd_word : '0;
    end

    // A byte handed to the transmitter makes it busy on the next cycle
    a_tx_taken : assert property (
        @(posedge Clock) disable iff (!rst_n) tx_valid |=> !tx_ready);

endmodule

// File: verilog/io_top.sv
// Top of the memory-mapped I/O block.
// Ties the decoder to the UART pair and to the line engine command
// port. Serial pins and the engine handshake leave from here.

`timescale 1ns/1ps

module io_top (
    input  logic                     Clock,
    input  logic                     rst_n,
    input  io_bus_pkg::cpu_req_t     req,
    input  logic                     stall,
    output logic [31:0]              rdata,
    output logic                     rdata_valid,
    input  logic                     serial_in,
    output logic                     serial_out,
    input  logic                     le_credit,
    output logic                     le_cmd_valid,
    output line_engine_pkg::le_cmd_t le_cmd
);

    logic                     tx_valid;
    logic [7:0]               tx_byte;
    logic                     tx_ready;
    logic                     rx_valid;
    logic [7:0]               rx_byte;
    logic                     rx_pop;
    logic                     enq_valid;
    line_engine_pkg::le_cmd_t enq_cmd;
    logic [2:0]               free_slots;
    logic                     overflow;
    logic                     overflow_clear;

    io_decoder u_decoder (
        .Clock, .rst_n, .req, .stall, .rdata, .rdata_valid,
        .tx_valid, .tx_byte, .tx_ready,
        .rx_valid, .rx_byte, .rx_pop,
        .enq_valid, .enq_cmd, .free_slots, .overflow, .overflow_clear
    );

    uart_tx u_uart_tx (
        .Clock, .rst_n, .tx_valid, .tx_byte, .tx_ready, .serial_out
    );

    uart_rx u_uart_rx (
        .Clock, .rst_n, .serial_in, .rx_valid, .rx_byte, .rx_pop
    );

    le_cmd_port u_le_cmd_port (
        .Clock, .rst_n, .enq_valid, .enq_cmd, .free_slots, .overflow,
        .overflow_clear, .le_credit, .le_cmd_valid, .le_cmd
    );

endmodule

// File: sim/io_tb.sv
// Testbench for the memory-mapped I/O block.
// Runs counter, UART loopback, line engine and back-pressure tests from
// a fixed seed and checks every response against a local model.

`timescale 1ns/1ps

`include "io_settings.svh"

module io_tb;

    localparam logic [31:0] BASE = `IO_BASE_ADDR;
    localparam int DEPTH         = `LE_QUEUE_DEPTH;
    localparam int N_BYTES       = 20;
    localparam int N_CMDS        = 200;
    localparam int CYCLE_LIMIT   = N_BYTES * (10 * `UART_CLKS_PER_BIT + 20)
                                   + N_CMDS * 8 + 2000;
    localparam logic [7:0] LE_OFFS [9] = '{8'h28, 8'h30, 8'h34, 8'h38, 8'h3C,
                                          8'h40, 8'h44, 8'h48, 8'h4C};

    logic                     Clock;
    logic                     rst_n;
    io_bus_pkg::cpu_req_t     req;
    logic                     stall;
    logic [31:0]              rdata;
    logic                     rdata_valid;
    logic                     serial_line;
    logic                     le_credit;
    logic                     le_cmd_valid;
    line_engine_pkg::le_cmd_t le_cmd;

    // Model state
    integer                   seed;
    int                       cycle_cnt;
    int                       err_word;
    int                       err_byte;
    int                       err_cmd;
    int                       err_other;
    int                       outstanding;
    logic                     credit_en;
    logic                     m_ovf;
    logic [31:0]              m_cycles;
    logic [31:0]              m_instrs;
    logic [31:0]              rd_word;
    line_engine_pkg::le_cmd_t exp_q [$];

    io_top dut0 (
        .Clock, .rst_n, .req, .stall, .rdata, .rdata_valid,
        .serial_in(serial_line), .serial_out(serial_line),
        .le_credit, .le_cmd_valid, .le_cmd
    );

    always #20 Clock = ~Clock;

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge Clock);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic compare_word(input logic [31:0] got, input logic [31:0] want,
                                input string what);
        if (got !== want) begin
            err_word++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] want,
                                input string what);
        if (got !== want) begin
            err_byte++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic compare_cmd(input line_engine_pkg::le_cmd_t got,
                               input line_engine_pkg::le_cmd_t want, input string what);
        if (got !== want) begin
            err_cmd++;
            $display("Fail at %0t: %s got %0d/%h/%b expected %0d/%h/%b", $time, what,
                     got.field, got.value, got.trigger, want.field, want.value, want.trigger);
        end
    endtask

    // Command the engine should see for a store to off
    function automatic logic le_command(input logic [7:0] off, input logic [31:0] wd,
                                        output line_engine_pkg::le_cmd_t cmd);
        cmd = '{field: line_engine_pkg::FIELD_X0, value: {14'b0, wd[9:0]},
                trigger: off[7:4] == 4'h4};
        case (off)
            8'h28: cmd = '{field: line_engine_pkg::FIELD_COLOR, value: wd[23:0], trigger: 1'b0};
            8'h30, 8'h40: cmd.field = line_engine_pkg::FIELD_X0;
            8'h34, 8'h44: cmd.field = line_engine_pkg::FIELD_Y0;
            8'h38, 8'h48: cmd.field = line_engine_pkg::FIELD_X1;
            8'h3C, 8'h4C: cmd.field = line_engine_pkg::FIELD_Y1;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic logic [31:0] le_status_word();
        return {23'b0, m_ovf, 5'b0, 3'(DEPTH - exp_q.size())};
    endfunction

    function automatic logic [7:0] random_le_offset();
        logic [31:0] r;
        r = $random(seed);
        return LE_OFFS[r[7:4] % 4'd9];
    endfunction

    // One request cycle from a falling edge to the next
    task automatic bus_cycle(input logic v, input io_bus_pkg::cpu_op_e op,
                             input logic [31:0] addr, input logic [31:0] wd);
        logic                     in_win;
        logic                     is_le;
        logic [31:0]              r;
        line_engine_pkg::le_cmd_t cmd;
        in_win    = v && (addr[31:8] == BASE[31:8]);
        r         = $random(seed);
        req       = '{valid: v, op: op, addr: addr, wdata: wd};
        stall     = r[0];
        le_credit = credit_en && (outstanding > 0) && r[1];
        if (le_credit) begin
            outstanding--;
        end
        // Counter values that a load in the next cycle returns
        if (in_win && op == io_bus_pkg::OP_STORE && addr[7:0] == io_bus_pkg::CNT_CLEAR) begin
            m_cycles = 32'h0;
            m_instrs = 32'h0;
        end else begin
            m_cycles = m_cycles + 32'd1;
            m_instrs = m_instrs + {31'b0, !r[0]};
        end
        is_le = le_command(addr[7:0], wd, cmd);
        if (in_win && op == io_bus_pkg::OP_STORE && is_le) begin
            if (exp_q.size() < DEPTH) begin
                exp_q.push_back(cmd);
            end else begin
                m_ovf = 1'b1;
            end
        end
        if (in_win && op == io_bus_pkg::OP_LOAD && addr[7:0] == io_bus_pkg::LE_STATUS) begin
            m_ovf = 1'b0;
        end
        @(negedge Clock);
        rd_word = rdata;
        if (rdata_valid !== (in_win && op == io_bus_pkg::OP_LOAD)) begin
            err_other++;
            $display("Fail at %0t: rdata_valid is %b after a request to %h",
                     $time, rdata_valid, addr);
        end
        // Line engine stand-in accepts every issued command
        if (le_cmd_valid) begin
            outstanding++;
            if (outstanding > `LE_CREDITS) begin
                err_other++;
                $display("More than %0d commands outstanding at %0t", `LE_CREDITS, $time);
            end
            if (exp_q.size() == 0) begin
                err_other++;
                $display("A command was issued at %0t while none was expected", $time);
            end else begin
                compare_cmd(le_cmd, exp_q.pop_front(), "issued command");
            end
        end
    endtask

    task automatic load_reg(input logic [7:0] off, output logic [31:0] data);
        bus_cycle(1'b1, io_bus_pkg::OP_LOAD, BASE | {24'h0, off}, $random(seed));
        data = rd_word;
    endtask

    task automatic store_reg(input logic [7:0] off, input logic [31:0] wd);
        bus_cycle(1'b1, io_bus_pkg::OP_STORE, BASE | {24'h0, off}, wd);
    endtask

    task automatic idle();
        bus_cycle(1'b0, io_bus_pkg::OP_STORE, $random(seed), $random(seed));
    endtask

    initial begin : main
        logic [31:0] d;
        logic [31:0] r;
        logic [31:0] want;
        logic [63:0] zero_offs;
        int          n;
        Clock       = 1'b0;
        rst_n       = 1'b0;
        req         = '{valid: 1'b0, op: io_bus_pkg::OP_OTHER, addr: 32'h0, wdata: 32'h0};
        stall       = 1'b0;
        le_credit   = 1'b0;
        seed        = 51;
        err_word    = 0;
        err_byte    = 0;
        err_cmd     = 0;
        err_other   = 0;
        outstanding = 0;
        credit_en   = 1'b1;
        m_ovf       = 1'b0;
        m_cycles    = 32'h0;
        m_instrs    = 32'h0;
        repeat (10) @(negedge Clock);
        if (rdata_valid !== 1'b0 || le_cmd_valid !== 1'b0 || serial_line !== 1'b1) begin
            err_other++;
            $display("Outputs are not at their reset values at %0t", $time);
        end
        rst_n = 1'b1;
        load_reg(io_bus_pkg::UART_STATUS, d);
        compare_word(d, 32'h1, "UART status after reset");
        load_reg(io_bus_pkg::LE_STATUS, d);
        compare_word(d, 32'h4, "LE status after reset");

        // ------------------------------
        // Counters and UART loopback
        // ------------------------------
        repeat (3) begin
            store_reg(io_bus_pkg::CNT_CLEAR, $random(seed));
            n = 20 + ($unsigned($random(seed)) % 30);
            repeat (n) idle();
            want = m_cycles;
            load_reg(io_bus_pkg::CYCLES, d);
            compare_word(d, want, "cycle counter");
            want = m_instrs;
            load_reg(io_bus_pkg::INSTRS, d);
            compare_word(d, want, "instruction counter");
        end
        repeat (N_BYTES) begin
            r = $random(seed);
            d = 32'h0;
            while (!d[0]) load_reg(io_bus_pkg::UART_STATUS, d);
            store_reg(io_bus_pkg::UART_TXDATA, r);
            load_reg(io_bus_pkg::UART_STATUS, d);
            compare_word(d, 32'h0, "UART status while sending");
            d = 32'h0;
            while (!d[1]) load_reg(io_bus_pkg::UART_STATUS, d);
            load_reg(io_bus_pkg::UART_RXDATA, d);
            compare_byte(d[7:0], r[7:0], "received byte");
            compare_word(d & 32'hFFFF_FF00, 32'h0, "upper bits of received data");
            load_reg(io_bus_pkg::UART_STATUS, d);
            compare_word(d, 32'h1, "UART status after pop");
        end

        // ------------------------------
        // Line engine commands
        // ------------------------------
        repeat (N_CMDS) begin
            r = $random(seed);
            case (r[9:8])
                2'd2: begin
                    load_reg(random_le_offset(), d);
                    compare_word(d, 32'h0, "load of a write-only LE offset");
                end
                2'd3: begin
                    bus_cycle(1'b1, io_bus_pkg::OP_OTHER,
                              BASE | {24'h0, random_le_offset()}, r);
                end
                default: begin
                    if (exp_q.size() < DEPTH) begin
                        store_reg(random_le_offset(), $random(seed));
                    end else begin
                        idle();
                    end
                end
            endcase
        end
        while (exp_q.size() != 0 || outstanding != 0) idle();
        // Credits held back until the queue and the engine are both full
        credit_en = 1'b0;
        while (exp_q.size() != DEPTH || outstanding != `LE_CREDITS) begin
            if (exp_q.size() < DEPTH) begin
                store_reg(random_le_offset(), $random(seed));
            end else begin
                idle();
            end
        end
        want = le_status_word();
        load_reg(io_bus_pkg::LE_STATUS, d);
        compare_word(d, want, "LE status with a full queue");
        repeat (3) begin
            store_reg(random_le_offset(), $random(seed));
            want = le_status_word();
            load_reg(io_bus_pkg::LE_STATUS, d);
            compare_word(d, want, "LE status under back-pressure");
        end
        want = le_status_word();
        load_reg(io_bus_pkg::LE_STATUS, d);
        compare_word(d, want, "LE status after overflow clear");
        credit_en = 1'b1;
        while (exp_q.size() != 0 || outstanding != 0) idle();

        // Write-only, unmapped and out-of-window loads
        zero_offs = 64'h080C_181C_202C_50FC;
        repeat (8) begin
            load_reg(zero_offs[63:56], d);
            compare_word(d, 32'h0, "write-only or unmapped offset");
            zero_offs = zero_offs << 8;
        end
        repeat (16) begin
            r = $random(seed);
            load_reg(8'h50 + {r[7:2] % 6'd44, 2'b00}, d);
            compare_word(d, 32'h0, "unmapped offset");
        end
        bus_cycle(1'b1, io_bus_pkg::OP_LOAD, 32'h9000_0010, 32'h0);
        bus_cycle(1'b1, io_bus_pkg::OP_LOAD, BASE + 32'h100, 32'h0);
        repeat (4) idle();

        $display("Error counts: word %0d, byte %0d, command %0d, other %0d",
                 err_word, err_byte, err_cmd, err_other);
        if (err_word + err_byte + err_cmd + err_other == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: io_subsys.f
+incdir+include
verilog/io_bus_pkg.sv
verilog/line_engine_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/le_cmd_port.sv
verilog/io_decoder.sv
verilog/io_top.sv
sim/io_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := io_tb
LINT_TOP  := io_top
FILELIST  := io_subsys.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/io_settings.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
